// ==== fp_add_config.svh ====
`ifndef FP_ADD_CONFIG_SVH
`define FP_ADD_CONFIG_SVH

// IEEE single precision field widths
`define FP_EXP_W   8
`define FP_MAN_W   23

// All-ones exponent, marks infinity and the overflow limit
`define FP_EXP_MAX 255

// Quiet NaN returned on invalid operations
`define FP_QNAN    32'h7fc00000

`endif

// ==== fp_add_pkg.sv ====
`include "fp_add_config.svh"

package fp_add_pkg;

  ////////////////////////////////////////////////////////////
  // Vector types shared by the pipeline stages
  ////////////////////////////////////////////////////////////

  // Full word: sign, exponent, stored mantissa
  typedef logic [`FP_EXP_W+`FP_MAN_W:0] fp_word_t;

  // Biased exponent
  typedef logic [`FP_EXP_W-1:0]         fp_exp_t;

  // Significand with hidden bit
  typedef logic [`FP_MAN_W:0]           fp_sig_t;

  // Significand sum, MSB is the carry
  typedef logic [`FP_MAN_W+1:0]         fp_sum_t;

  // Leading zero count over a significand
  typedef logic [4:0]                   fp_lzc_t;

endpackage

// ==== fp_align_if.sv ====
interface fp_align_if;

  import fp_add_pkg::*;

  logic    valid;       // One-cycle strobe
  logic    sign;        // Sign of larger operand (or of the infinity)
  fp_exp_t exp;         // Exponent of larger operand
  fp_sig_t sig_big;     // Larger significand
  fp_sig_t sig_small;   // Smaller significand, already aligned
  logic    eff_sub;     // Effective signs differ
  logic    is_inf;      // At least one infinite operand
  logic    is_invalid;  // Infinities of opposite effective sign

  // Align stage side
  modport src (
    output valid, sign, exp, sig_big, sig_small,
    output eff_sub, is_inf, is_invalid
  );

  // Adder stage side
  modport dst (
    input valid, sign, exp, sig_big, sig_small,
    input eff_sub, is_inf, is_invalid
  );

endinterface

// ==== fp_sum_if.sv ====
interface fp_sum_if;

  import fp_add_pkg::*;

  logic    valid;       // One-cycle strobe
  logic    sign;        // Result sign
  fp_exp_t exp;         // Exponent before normalization
  fp_sum_t sum;         // Raw significand sum with carry
  logic    eff_sub;     // Sum came from a subtraction
  logic    is_inf;
  logic    is_invalid;

  // Adder stage side
  modport src (
    output valid, sign, exp, sum, eff_sub, is_inf, is_invalid
  );

  // Normalize stage side
  modport dst (
    input valid, sign, exp, sum, eff_sub, is_inf, is_invalid
  );

endinterface

// ==== fp_operand_align.sv ====
`include "fp_add_config.svh"

module fp_operand_align
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                valid_i,
  input  logic                op_sub_i,   // Subtract b from a
  input  fp_add_pkg::fp_word_t a_i,
  input  fp_add_pkg::fp_word_t b_i,
  fp_align_if.src             align_o
);

  import fp_add_pkg::*;

  logic    sign_a, sign_b;
  fp_exp_t exp_a, exp_b;
  fp_sig_t sig_a, sig_b;
  logic    inf_a, inf_b, any_inf;
  logic    a_ge_b;
  fp_exp_t exp_big, exp_small, exp_diff;
  fp_sig_t sig_small_raw, sig_shift;

  ////////////////////////////////////////////////////////////
  // Unpack and special cases
  ////////////////////////////////////////////////////////////

  assign sign_a = a_i[`FP_EXP_W+`FP_MAN_W];
  assign sign_b = b_i[`FP_EXP_W+`FP_MAN_W] ^ op_sub_i;   // Flip on subtraction
  assign exp_a  = a_i[`FP_MAN_W +: `FP_EXP_W];
  assign exp_b  = b_i[`FP_MAN_W +: `FP_EXP_W];
  assign sig_a  = {1'b1, a_i[`FP_MAN_W-1:0]};            // Hidden bit always set
  assign sig_b  = {1'b1, b_i[`FP_MAN_W-1:0]};

  assign inf_a   = (exp_a == `FP_EXP_MAX);
  assign inf_b   = (exp_b == `FP_EXP_MAX);
  assign any_inf = inf_a | inf_b;

  // Magnitude order by exponent first then mantissa
  // An infinity always wins, so the big sign is the infinity's sign
  assign a_ge_b = (a_i[`FP_EXP_W+`FP_MAN_W-1:0] >= b_i[`FP_EXP_W+`FP_MAN_W-1:0]);

  assign exp_big       = a_ge_b ? exp_a : exp_b;
  assign exp_small     = a_ge_b ? exp_b : exp_a;
  assign sig_small_raw = a_ge_b ? sig_b : sig_a;
  assign exp_diff      = exp_big - exp_small;

  // Shifted-out bits dropped and nothing left at a distance of 24 or more
  assign sig_shift = (exp_diff > `FP_MAN_W) ? '0 : (sig_small_raw >> exp_diff);

  ////////////////////////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      align_o.valid <= 1'b0;
    else
      align_o.valid <= valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (valid_i)
    begin
      align_o.sign       <= a_ge_b ? sign_a : sign_b;
      align_o.exp        <= exp_big;
      align_o.sig_big    <= a_ge_b ? sig_a : sig_b;
      align_o.sig_small  <= sig_shift;
      align_o.eff_sub    <= sign_a ^ sign_b;
      align_o.is_inf     <= any_inf;
      align_o.is_invalid <= inf_a & inf_b & (sign_a ^ sign_b);
    end
  end

  // Registered exponent belongs to the larger operand
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i && !any_inf |=> ($past(exp_small) <= align_o.exp));

endmodule

// ==== fp_significand_adder.sv ====
module fp_significand_adder
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  fp_align_if.dst align_i,
  fp_sum_if.src   sum_o
);

  import fp_add_pkg::*;

  fp_sum_t big_ext, small_ext;
  fp_sum_t sum_d;

  ////////////////////////////////////////////////////////////
  // Significand add / subtract
  ////////////////////////////////////////////////////////////

  assign big_ext   = fp_sum_t'(align_i.sig_big);     // Zero extend for carry
  assign small_ext = fp_sum_t'(align_i.sig_small);

  // Big minus small never goes negative
  assign sum_d = align_i.eff_sub ? (big_ext - small_ext) : (big_ext + small_ext);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      sum_o.valid <= 1'b0;
    else
      sum_o.valid <= align_i.valid;
  end

  always_ff @(posedge clk_i)
  begin
    if (align_i.valid)
    begin
      sum_o.sign       <= align_i.sign;
      sum_o.exp        <= align_i.exp;
      sum_o.sum        <= sum_d;
      sum_o.eff_sub    <= align_i.eff_sub;
      sum_o.is_inf     <= align_i.is_inf;       // Special flags just ride along
      sum_o.is_invalid <= align_i.is_invalid;
    end
  end

  // Ordering in the align stage keeps a subtraction from borrowing
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sum_o.valid && sum_o.eff_sub |-> !sum_o.sum[$bits(fp_sum_t)-1]);

endmodule

// ==== fp_normalize_out.sv ====
`include "fp_add_config.svh"

module fp_normalize_out
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  fp_sum_if.dst                sum_i,
  output logic                 valid_o,
  output fp_add_pkg::fp_word_t result_o,
  output logic                 overflow_o,
  output logic                 underflow_o,
  output logic                 invalid_o
);

  import fp_add_pkg::*;

  fp_lzc_t                     lzc;
  logic                        carry, zero;
  logic signed [`FP_EXP_W+1:0] exp_ext, lzc_ext, exp_norm;
  fp_sig_t                     sig_norm;
  fp_word_t                    result_d;
  logic                        ovf_d, udf_d, inv_d;

  ////////////////////////////////////////////////////////////
  // Leading zero count, highest set bit wins
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    lzc = '0;
    for (int i = 0; i <= `FP_MAN_W; i++)
      if (sum_i.sum[i])
        lzc = fp_lzc_t'(`FP_MAN_W - i);
  end

  assign carry   = sum_i.sum[`FP_MAN_W+1] & ~sum_i.eff_sub;   // Only an addition carries
  assign zero    = (sum_i.sum == '0);
  assign exp_ext = {2'b00, sum_i.exp};
  assign lzc_ext = {{(`FP_EXP_W + 2 - $bits(fp_lzc_t)){1'b0}}, lzc};

  always_comb
  begin
    if (carry)
    begin
      sig_norm = sum_i.sum[`FP_MAN_W+1:1];
      exp_norm = exp_ext + 1;
    end
    else
    begin
      sig_norm = sum_i.sum[`FP_MAN_W:0] << lzc;
      exp_norm = exp_ext - lzc_ext;
    end
  end

  // Special results first, then range checks
  always_comb
  begin
    ovf_d    = 1'b0;
    udf_d    = 1'b0;
    inv_d    = 1'b0;
    result_d = {sum_i.sign, exp_norm[`FP_EXP_W-1:0], sig_norm[`FP_MAN_W-1:0]};
    if (sum_i.is_invalid)
    begin
      result_d = `FP_QNAN;
      inv_d    = 1'b1;
    end
    else if (sum_i.is_inf)
      result_d = {sum_i.sign, fp_exp_t'(`FP_EXP_MAX), {`FP_MAN_W{1'b0}}};
    else if (zero)
      result_d = '0;                                           // Always +0
    else if (exp_norm >= `FP_EXP_MAX)
    begin
      result_d = {sum_i.sign, fp_exp_t'(`FP_EXP_MAX), {`FP_MAN_W{1'b0}}};
      ovf_d    = 1'b1;
    end
    else if (exp_norm <= 0)
    begin
      result_d = '0;
      udf_d    = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      valid_o     <= 1'b0;
      overflow_o  <= 1'b0;
      underflow_o <= 1'b0;
      invalid_o   <= 1'b0;
    end
    else
    begin
      valid_o     <= sum_i.valid;
      overflow_o  <= sum_i.valid & ovf_d;   // Quiet between results
      underflow_o <= sum_i.valid & udf_d;
      invalid_o   <= sum_i.valid & inv_d;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (sum_i.valid)
      result_o <= result_d;
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({overflow_o, underflow_o, invalid_o}));

endmodule

// ==== fp_add_top.sv ====
module fp_add_top
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 valid_i,      // One operation per strobe
  input  logic                 op_sub_i,     // 1 for a - b
  input  fp_add_pkg::fp_word_t a_i,
  input  fp_add_pkg::fp_word_t b_i,
  output logic                 valid_o,      // Three cycles after valid_i
  output fp_add_pkg::fp_word_t result_o,
  output logic                 overflow_o,
  output logic                 underflow_o,
  output logic                 invalid_o
);

  fp_align_if u_align_if ();
  fp_sum_if   u_sum_if ();

  ////////////////////////////////////////////////////////////
  // Align, add, normalize
  ////////////////////////////////////////////////////////////

  fp_operand_align u_align (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .valid_i  (valid_i),
    .op_sub_i (op_sub_i),
    .a_i      (a_i),
    .b_i      (b_i),
    .align_o  (u_align_if.src)
  );

  fp_significand_adder u_adder (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .align_i (u_align_if.dst),
    .sum_o   (u_sum_if.src)
  );

  fp_normalize_out u_normalize (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .sum_i       (u_sum_if.dst),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .overflow_o  (overflow_o),
    .underflow_o (underflow_o),
    .invalid_o   (invalid_o)
  );

endmodule

// ==== tb_fp_add.sv ====
module tb_fp_add;

  localparam int NUM_OPS    = 3000;
  localparam int MAX_CYCLES = 8000;

  logic        clk = 1'b0;
  logic        rst_n, valid, op_sub;
  logic [31:0] a, b;
  logic        valid_o, overflow_o, underflow_o, invalid_o;
  logic [31:0] result_o;

  logic [31:0] lcg_state = 32'hfc94dce7;
  int          edge_cnt = 0;
  int          issued, seen, cycles, wait_cnt;
  logic [34:0] expect_q[$];                  // {overflow, underflow, invalid, result}
  int          due_q[$];                     // Edge count when each result is due
  logic [34:0] expected;
  int          due;
  logic [31:0] rnd, op_a, op_b;

  fp_add_top u_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .valid_i     (valid),
    .op_sub_i    (op_sub),
    .a_i         (a),
    .b_i         (b),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .overflow_o  (overflow_o),
    .underflow_o (underflow_o),
    .invalid_o   (invalid_o)
  );

  always #10 clk = ~clk;

  always @(posedge clk)
    edge_cnt <= edge_cnt + 1;

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Normal number or infinity with exponents often near 1 and 254
  function automatic logic [31:0] random_operand();
    logic [31:0] r;
    logic [31:0] s;
    logic [7:0]  e;
    r = next_random();
    s = next_random();
    if (r[31:28] == 4'd0)
      return {s[31], 8'hff, 23'd0};
    if (r[31:28] <= 4'd2)
      e = 8'd254 - {7'd0, s[30]};
    else if (r[31:28] <= 4'd4)
      e = 8'd1 + {7'd0, s[30]};
    else
      e = (s[30:23] % 8'd254) + 8'd1;
    return {s[31], e, s[22:0]};
  endfunction

  // Second operand often close to the first so that sums cancel or carry
  function automatic logic [31:0] partner_operand(input logic [31:0] first);
    logic [31:0] r;
    logic [7:0]  e;
    r = next_random();
    if (first[30:23] == 8'hff)
      return r[31] ? {r[30], 8'hff, 23'd0} : random_operand();
    if (r[31:30] != 2'd0)
      return random_operand();
    e = first[30:23];
    if (r[29:28] == 2'd2 && e < 8'd254)
      e = e + 8'd1;
    else if (r[29:28] == 2'd3 && e > 8'd1)
      e = e - 8'd1;
    return {r[25], e, first[22:0] ^ ((r[27:26] == 2'd0) ? 23'd0 : {7'd0, r[15:0]})};
  endfunction

  // Reference model returning {overflow, underflow, invalid, result}
  function automatic logic [34:0] model_result(input logic sub, input logic [31:0] x,
                                               input logic [31:0] y);
    logic sx, sy, sr;
    int   ex, ey, e, shift, mbig, msmall, sum;
    sx = x[31];
    sy = y[31] ^ sub;
    ex = int'(x[30:23]);
    ey = int'(y[30:23]);
    if (ex == 255 && ey == 255 && sx != sy)
      return {3'b001, 32'h7fc00000};
    if (ex == 255)
      return {3'b000, sx, 8'hff, 23'd0};
    if (ey == 255)
      return {3'b000, sy, 8'hff, 23'd0};
    if ((ex > ey) || (ex == ey && x[22:0] >= y[22:0]))
    begin
      sr = sx;
      e = ex;
      shift = ex - ey;
      mbig = int'({1'b1, x[22:0]});
      msmall = int'({1'b1, y[22:0]});
    end
    else
    begin
      sr = sy;
      e = ey;
      shift = ey - ex;
      mbig = int'({1'b1, y[22:0]});
      msmall = int'({1'b1, x[22:0]});
    end
    msmall = (shift >= 24) ? 0 : (msmall >> shift);
    sum = (sx != sy) ? (mbig - msmall) : (mbig + msmall);
    if (sum == 0)
      return 35'd0;                           // Exact cancellation gives +0
    if (sum >= (1 << 24))
    begin
      sum = sum >> 1;
      e = e + 1;
    end
    while (sum < (1 << 23))
    begin
      sum = sum << 1;
      e = e - 1;
    end
    if (e >= 255)
      return {3'b100, sr, 8'hff, 23'd0};
    if (e <= 0)
      return {3'b010, 32'd0};
    return {3'b000, sr, e[7:0], sum[22:0]};
  endfunction

  ////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected_val,
                             input logic [31:0] actual_val);
    if (actual_val !== expected_val)
      stop_on_failure($sformatf("error %s: expected %h, actual %h",
                                name, expected_val, actual_val));
  endtask

  // Outputs sampled on the falling edge
  always @(negedge clk)
  begin
    if (rst_n && valid_o)
    begin
      if (expect_q.size() == 0)
        stop_on_failure("valid_o went high with no operation in flight");
      else
      begin
        expected = expect_q.pop_front();
        due = due_q.pop_front();
        check_value($sformatf("latency of op %0d", seen), due, edge_cnt);
        check_value($sformatf("result of op %0d", seen), expected[31:0], result_o);
        check_value($sformatf("flags of op %0d", seen), {29'd0, expected[34:32]},
                    {29'd0, overflow_o, underflow_o, invalid_o});
        seen++;
      end
    end
  end

  initial
  begin
    rst_n = 1'b0;
    valid = 1'b0;
    op_sub = 1'b0;
    a = 32'd0;
    b = 32'd0;
    issued = 0;
    seen = 0;
    cycles = 0;
    wait_cnt = 0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("valid_o after reset", 32'd0, {31'd0, valid_o});
    check_value("flags after reset", 32'd0, {29'd0, overflow_o, underflow_o, invalid_o});

    while (issued < NUM_OPS && cycles < MAX_CYCLES)
    begin
      @(posedge clk);
      cycles++;
      rnd = next_random();
      op_a = random_operand();
      op_b = partner_operand(op_a);
      a <= op_a;
      b <= op_b;
      op_sub <= rnd[29];
      valid <= (rnd[31:30] != 2'd0);          // Gaps about one cycle in four
      if (rnd[31:30] != 2'd0)
      begin
        expect_q.push_back(model_result(rnd[29], op_a, op_b));
        due_q.push_back(edge_cnt + 4);        // DUT samples on the next edge, then three stages
        issued++;
      end
    end
    @(posedge clk);
    valid <= 1'b0;

    while (expect_q.size() != 0 && wait_cnt < 20)
    begin
      @(posedge clk);
      wait_cnt++;
    end
    repeat (5) @(posedge clk);
    if (issued == NUM_OPS && expect_q.size() == 0 && seen == NUM_OPS)
    begin
      $display(">>> PASS");
      $finish;
    end
    else
      stop_on_failure($sformatf("results went missing: %0d sent, %0d came out of %0d",
                                issued, seen, NUM_OPS));
  end

endmodule

// ==== fp_add.f ====
+incdir+.
fp_add_pkg.sv
fp_align_if.sv
fp_sum_if.sv
fp_operand_align.sv
fp_significand_adder.sv
fp_normalize_out.sv
fp_add_top.sv
tb_fp_add.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the floating-point adder testbench with Verilator

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f fp_add.f \
  --top-module tb_fp_add -o tb_fp_add > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/tb_fp_add > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error status"
fi

if grep -q "^>>> PASS$" "$SIM_LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed, see $SIM_LOG"
exit 1
